// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench.
# The run target fails when the simulation exits with an error.

OBJ_DIR = obj_dir
SIM     = $(OBJ_DIR)/sim_mem_subsys

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): filelist.f verilog/*.sv verif/*.sv
	verilator --binary --timing -j 0 --top-module tb_mem_subsys \
		--Mdir $(OBJ_DIR) -o sim_mem_subsys -f filelist.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
verilog/mem_pkg.sv
verilog/bram_512x128.sv
verilog/sram_1rw_512x128.sv
verilog/mem_req_stage.sv
verilog/mem_req_fifo.sv
verilog/mem_access_ctrl.sv
verilog/mem_subsys_top.sv
verif/tb_clock_gen.sv
verif/tb_mem_subsys.sv

// ==== verif/tb_clock_gen.sv ====
// Testbench clock source
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int period = 4
) (
   output logic memclk
);

   // free running, starts low.
   initial begin
      memclk = 1'b0;
      forever begin
         #(period / 2) memclk = ~memclk;
      end
   end

endmodule

// ==== verif/tb_mem_subsys.sv ====
// Memory subsystem testbench
`timescale 1ns/1ps

module tb_mem_subsys;

   localparam int CLK_PERIOD = 4;
   // operations issued by all phases together.
   localparam int NUM_OPS = 1024 + 128 + 200 + 16 + 300;

   logic                       memclk;
   logic                       reset;
   logic                       req_valid;
   logic                       req_write;
   logic [mem_pkg::ADDR_W-1:0] req_addr;
   logic [mem_pkg::DATA_W-1:0] req_wdata;
   logic [mem_pkg::BE_W-1:0]   req_be;
   logic                       req_ready;
   logic                       rsp_valid;
   logic [mem_pkg::DATA_W-1:0] rsp_rdata;
   logic                       rsp_ready;

   integer                     seed = 32'hf9f0;
   // response mode is 0 for always ready, 1 for random and 2 for held low.
   int                         rsp_mode = 0;
   int                         ready_low_count = 0;
   logic                       held = 1'b0;
   logic [mem_pkg::DATA_W-1:0] held_data;
   logic [mem_pkg::DATA_W-1:0] model [0:mem_pkg::DEPTH_WORDS-1];
   logic [mem_pkg::DATA_W-1:0] exp_q [$];

   tb_clock_gen #(.period(CLK_PERIOD)) clk0 (.memclk(memclk));

   mem_subsys_top #(.fifo_depth(4)) dut0 (
      .memclk    (memclk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_write (req_write),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .req_be    (req_be),
      .req_ready (req_ready),
      .rsp_valid (rsp_valid),
      .rsp_rdata (rsp_rdata),
      .rsp_ready (rsp_ready)
   );

   task automatic check_value(input string name, input logic [mem_pkg::DATA_W-1:0] got,
                              input logic [mem_pkg::DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("error: %s is %h, expected %h", name, got, exp);
         $display("Test failed");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   function automatic logic [mem_pkg::DATA_W-1:0] rand_word();
      rand_word = {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   // a write merges only its enabled bytes, a read queues the word it should see.
   task automatic record_request();
      if (req_write) begin
         for (int i = 0; i < mem_pkg::BE_W; i++)
            if (req_be[i]) model[req_addr][8*i +: 8] = req_wdata[8*i +: 8];
      end else begin
         exp_q.push_back(model[req_addr]);
      end
   endtask

   task automatic take_response();
      if (exp_q.size() == 0) begin
         $display("Test failed");
         $fatal(1, "a response arrived with no read waiting for it");
      end else begin
         check_value("rsp_rdata", rsp_rdata, exp_q.pop_front());
      end
   endtask

   // sampled just after the falling edge, where all inputs and outputs have settled.
   always @(negedge memclk) begin
      #1;
      if (!reset) begin
         // a held response must keep valid and data.
         if (held) begin
            check_value("rsp_valid", mem_pkg::DATA_W'(rsp_valid), mem_pkg::DATA_W'(1));
            check_value("rsp_rdata", rsp_rdata, held_data);
         end
         held      = rsp_valid & ~rsp_ready;
         held_data = rsp_rdata;
         if (!req_ready) ready_low_count++;
         if (req_valid && req_ready) record_request();
         if (rsp_valid && rsp_ready) take_response();
      end
   end

   // response back-pressure.
   initial begin
      rsp_ready = 1'b1;
      forever begin
         @(negedge memclk);
         case (rsp_mode)
            1: rsp_ready = (($random(seed) & 3) != 0);
            2: rsp_ready = 1'b0;
            default: rsp_ready = 1'b1;
         endcase
      end
   end

   // holds the request until it is taken, returns at the accepting edge.
   task automatic send_req(input logic write, input logic [mem_pkg::ADDR_W-1:0] addr,
                           input logic [mem_pkg::DATA_W-1:0] data,
                           input logic [mem_pkg::BE_W-1:0] be);
      @(negedge memclk);
      req_valid = 1'b1;
      req_write = write;
      req_addr  = addr;
      req_wdata = data;
      req_be    = be;
      #1;
      while (!req_ready) begin
         @(negedge memclk);
         #1;
      end
      @(posedge memclk);
   endtask

   task automatic idle(input int cycles);
      @(negedge memclk);
      req_valid = 1'b0;
      repeat (cycles) @(posedge memclk);
   endtask

   task automatic drain();
      int waited;
      idle(1);
      waited = 0;
      while (exp_q.size() != 0 && waited < 400) begin
         @(posedge memclk);
         waited++;
      end
   endtask

   // random read or write; writes get random data and byte enables.
   task automatic send_random(input logic write);
      logic [mem_pkg::ADDR_W-1:0] addr;
      logic [mem_pkg::DATA_W-1:0] data;
      logic [mem_pkg::BE_W-1:0]   be;
      addr = mem_pkg::ADDR_W'($random(seed));
      data = rand_word();
      be   = mem_pkg::BE_W'($random(seed));
      if (write) send_req(1'b1, addr, data, be);
      else send_req(1'b0, addr, '0, '0);
   endtask

   task automatic fill_and_read();
      for (int i = 0; i < mem_pkg::DEPTH_WORDS; i++)
         send_req(1'b1, mem_pkg::ADDR_W'(i), rand_word(), '1);
      for (int i = 0; i < mem_pkg::DEPTH_WORDS; i++)
         send_req(1'b0, mem_pkg::ADDR_W'(i), '0, '0);
      drain();
   endtask

   task automatic partial_writes();
      logic [mem_pkg::ADDR_W-1:0] addrs [$];
      logic [mem_pkg::DATA_W-1:0] data;
      logic [mem_pkg::BE_W-1:0]   be;
      for (int i = 0; i < 64; i++) begin
         addrs.push_back(mem_pkg::ADDR_W'($random(seed)));
         data = rand_word();
         be   = mem_pkg::BE_W'($random(seed));
         send_req(1'b1, addrs[i], data, be);
      end
      for (int i = 0; i < 64; i++) send_req(1'b0, addrs[i], '0, '0);
      drain();
   endtask

   // reads and writes while responses are held back long enough to fill the queue.
   task automatic stall_and_release();
      int base;
      base     = ready_low_count;
      rsp_mode = 2;
      fork
         for (int i = 0; i < 16; i++) send_random(i % 2 == 1);
         begin
            while (ready_low_count == base) @(posedge memclk);
            repeat (20) @(posedge memclk);
            // with every response held back the whole path is full by now.
            @(negedge memclk);
            #1;
            check_value("req_ready", mem_pkg::DATA_W'(req_ready), '0);
            rsp_mode = 0;
         end
      join
      drain();
   endtask

   initial begin
      reset     = 1'b1;
      req_valid = 1'b0;
      req_write = 1'b0;
      req_addr  = '0;
      req_wdata = '0;
      req_be    = '0;
      repeat (8) @(posedge memclk);
      @(negedge memclk);
      reset = 1'b0;
      @(negedge memclk);
      #1;
      check_value("req_ready", mem_pkg::DATA_W'(req_ready), mem_pkg::DATA_W'(1));
      check_value("rsp_valid", mem_pkg::DATA_W'(rsp_valid), '0);
      @(posedge memclk);
      fill_and_read();
      partial_writes();
      // reads only, with random back-pressure.
      rsp_mode = 1;
      for (int i = 0; i < 200; i++) send_random(1'b0);
      drain();
      rsp_mode = 0;
      stall_and_release();
      // mixed traffic with gaps on req_valid.
      rsp_mode = 1;
      for (int i = 0; i < 300; i++) begin
         send_random(($random(seed) & 1) == 1);
         if (($random(seed) & 3) == 0) idle(1 + ($random(seed) & 3));
      end
      rsp_mode = 0;
      drain();
      if (exp_q.size() != 0) begin
         $display("Test failed");
         $fatal(1, "%0d reads never got a response", exp_q.size());
      end else begin
         $display("Test passed");
         $finish;
      end
   end

   // watchdog allows 40 cycles per operation.
   initial begin
      #(NUM_OPS * 40 * CLK_PERIOD);
      $display("Test failed");
      $fatal(1, "timeout, the run did not finish within %0d cycles", NUM_OPS * 40);
   end

endmodule

// ==== verilog/bram_512x128.sv ====
// Dual-port block RAM
`timescale 1ns/1ps

module bram_512x128 (
   input  logic                       clka,
   input  logic                       ena,
   input  logic [mem_pkg::BE_W-1:0]   wea,
   input  logic [mem_pkg::ADDR_W-1:0] addra,
   input  logic [mem_pkg::DATA_W-1:0] dina,
   input  logic                       clkb,
   input  logic                       enb,
   input  logic [mem_pkg::ADDR_W-1:0] addrb,
   output logic [mem_pkg::DATA_W-1:0] doutb
);

   // storage array, one entry per word.
   logic [mem_pkg::DATA_W-1:0] ram [0:mem_pkg::DEPTH_WORDS-1];

   // port a is write only.
   // each byte lane is written only when its enable is set.
   always_ff @(posedge clka) begin
      if (ena) begin
         for (int i = 0; i < mem_pkg::BE_W; i++) begin
            if (wea[i]) begin
               ram[addra][8*i +: 8] <= dina[8*i +: 8];
            end
         end
      end
   end

   // port b is read only.
   // the word is registered on enable, doutb holds otherwise.
   always_ff @(posedge clkb) begin
      if (enb) begin
         doutb <= ram[addrb];
      end
   end

endmodule

// ==== verilog/mem_access_ctrl.sv ====
// SRAM access controller
`timescale 1ns/1ps

module mem_access_ctrl (
   input  logic                       memclk,
   input  logic                       reset,
   input  logic                       in_valid,
   input  logic [mem_pkg::REQ_W-1:0]  in_entry,
   input  logic [mem_pkg::DATA_W-1:0] dout,
   input  logic                       rsp_ready,
   output logic                       in_ready,
   output logic                       ce,
   output logic                       rdwen,
   output logic [mem_pkg::ADDR_W-1:0] a,
   output logic [mem_pkg::DATA_W-1:0] bw,
   output logic [mem_pkg::DATA_W-1:0] din,
   output logic                       rsp_valid,
   output logic [mem_pkg::DATA_W-1:0] rsp_rdata
);

   logic                       head_write;
   logic [mem_pkg::ADDR_W-1:0] head_addr;
   logic [mem_pkg::DATA_W-1:0] head_wdata;
   logic [mem_pkg::DATA_W-1:0] head_mask;
   logic                       rd_inflight;
   logic                       rd_in_sram;
   logic                       rsp_free;
   logic                       issue;

   // unpack the head entry.
   assign head_write = in_entry[mem_pkg::REQ_W-1];
   assign head_addr  = in_entry[mem_pkg::REQ_W-2 -: mem_pkg::ADDR_W];
   assign head_wdata = in_entry[2*mem_pkg::DATA_W-1 -: mem_pkg::DATA_W];
   assign head_mask  = in_entry[mem_pkg::DATA_W-1:0];

   // a read occupies the sram from issue until dout is captured.
   assign rd_in_sram = (ce & rdwen) | rd_inflight;
   assign rsp_free   = ~rsp_valid | rsp_ready;

   // writes always go; reads wait for a free sram and a free response slot.
   assign in_ready = head_write | (~rd_in_sram & rsp_free);
   assign issue    = in_valid & in_ready;

   // access registers feeding the sram wrapper.
   always_ff @(posedge memclk) begin
      if (reset) begin
         ce <= 1'b0;
      end else begin
         ce <= issue;
      end
   end

   always_ff @(posedge memclk) begin
      if (issue) begin
         rdwen <= ~head_write;
         a     <= head_addr;
         bw    <= head_mask;
         din   <= head_wdata;
      end
   end

   // set while dout holds the word of the last read.
   always_ff @(posedge memclk) begin
      if (reset) begin
         rd_inflight <= 1'b0;
      end else begin
         rd_inflight <= ce & rdwen;
      end
   end

   // response register.
   // the issue rule guarantees it is empty when read data lands.
   always_ff @(posedge memclk) begin
      if (reset) begin
         rsp_valid <= 1'b0;
      end else if (rd_inflight) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

   always_ff @(posedge memclk) begin
      if (rd_inflight) begin
         rsp_rdata <= dout;
      end
   end

endmodule

// ==== verilog/mem_pkg.sv ====
// Memory subsystem geometry
package mem_pkg;

   // word address width.
   localparam int ADDR_W = 9;

   // memory word width in bits.
   localparam int DATA_W = 128;

   // one enable per byte lane.
   localparam int BE_W = DATA_W / 8;

   // every address maps to a word, no holes.
   localparam int DEPTH_WORDS = 1 << ADDR_W;

   // queued request entry, msb first.
   //   write flag  (1 bit).
   //   address     (ADDR_W bits).
   //   write data  (DATA_W bits).
   //   bit mask    (DATA_W bits, zero for reads).
   localparam int REQ_W = 1 + ADDR_W + DATA_W + DATA_W;

endpackage

// ==== verilog/mem_req_fifo.sv ====
// Request FIFO
`timescale 1ns/1ps

module mem_req_fifo #(
   parameter int fifo_depth = 4
) (
   input  logic                      memclk,
   input  logic                      reset,
   input  logic                      in_valid,
   input  logic [mem_pkg::REQ_W-1:0] in_entry,
   input  logic                      out_ready,
   output logic                      in_ready,
   output logic                      out_valid,
   output logic [mem_pkg::REQ_W-1:0] out_entry
);

   // depth is a power of two, so the pointers wrap on their own.
   localparam int PTR_W = $clog2(fifo_depth);
   localparam int CNT_W = PTR_W + 1;

   logic [mem_pkg::REQ_W-1:0] store [0:fifo_depth-1];
   logic [PTR_W-1:0]          wr_ptr;
   logic [PTR_W-1:0]          rd_ptr;
   logic [CNT_W-1:0]          count;
   logic                      full;
   logic                      push;
   logic                      pop;

   assign full = (count == CNT_W'(fifo_depth));

   // a full fifo still takes a push when the head leaves this cycle.
   assign in_ready  = ~full | out_ready;
   assign out_valid = (count != '0);
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;

   // head read straight from the array.
   assign out_entry = store[rd_ptr];

   always_ff @(posedge memclk) begin
      if (push) begin
         store[wr_ptr] <= in_entry;
      end
   end

   always_ff @(posedge memclk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // occupancy moves only when exactly one side is active.
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// ==== verilog/mem_req_stage.sv ====
// Request input stage
`timescale 1ns/1ps

module mem_req_stage (
   input  logic                       memclk,
   input  logic                       reset,
   input  logic                       req_valid,
   input  logic                       req_write,
   input  logic [mem_pkg::ADDR_W-1:0] req_addr,
   input  logic [mem_pkg::DATA_W-1:0] req_wdata,
   input  logic [mem_pkg::BE_W-1:0]   req_be,
   input  logic                       out_ready,
   output logic                       req_ready,
   output logic                       out_valid,
   output logic [mem_pkg::REQ_W-1:0]  out_entry
);

   logic                       run;
   logic                       accept;
   logic [mem_pkg::DATA_W-1:0] bit_mask;

   // run goes high one cycle after reset is released.
   // requests are refused until then.
   always_ff @(posedge memclk) begin
      if (reset) begin
         run <= 1'b0;
      end else begin
         run <= 1'b1;
      end
   end

   // room when empty or draining this cycle.
   assign req_ready = run & (~out_valid | out_ready);
   assign accept    = req_valid & req_ready;

   // each byte enable covers eight mask bits.
   // reads carry no mask.
   always_comb begin
      for (int i = 0; i < mem_pkg::BE_W; i++) begin
         bit_mask[8*i +: 8] = {8{req_be[i] & req_write}};
      end
   end

   always_ff @(posedge memclk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (accept) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   // entry payload, loaded on accept only.
   always_ff @(posedge memclk) begin
      if (accept) begin
         out_entry <= {req_write, req_addr, req_wdata, bit_mask};
      end
   end

endmodule

// ==== verilog/mem_subsys_top.sv ====
// Memory subsystem top
`timescale 1ns/1ps

module mem_subsys_top #(
   parameter int fifo_depth = 4
) (
   input  logic                       memclk,
   input  logic                       reset,
   input  logic                       req_valid,
   input  logic                       req_write,
   input  logic [mem_pkg::ADDR_W-1:0] req_addr,
   input  logic [mem_pkg::DATA_W-1:0] req_wdata,
   input  logic [mem_pkg::BE_W-1:0]   req_be,
   output logic                       req_ready,
   output logic                       rsp_valid,
   output logic [mem_pkg::DATA_W-1:0] rsp_rdata,
   input  logic                       rsp_ready
);

   // request stage to fifo.
   logic                       stage_valid;
   logic                       fifo_ready;
   logic [mem_pkg::REQ_W-1:0]  stage_entry;

   // fifo to access controller.
   logic                       fifo_valid;
   logic                       ctrl_ready;
   logic [mem_pkg::REQ_W-1:0]  fifo_entry;

   // access controller to sram wrapper.
   logic                       ce;
   logic                       rdwen;
   logic [mem_pkg::ADDR_W-1:0] a;
   logic [mem_pkg::DATA_W-1:0] bw;
   logic [mem_pkg::DATA_W-1:0] din;
   logic [mem_pkg::DATA_W-1:0] dout;

   mem_req_stage stage0 (
      .memclk    (memclk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_write (req_write),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .req_be    (req_be),
      .out_ready (fifo_ready),
      .req_ready (req_ready),
      .out_valid (stage_valid),
      .out_entry (stage_entry)
   );

   mem_req_fifo #(
      .fifo_depth (fifo_depth)
   ) fifo0 (
      .memclk    (memclk),
      .reset     (reset),
      .in_valid  (stage_valid),
      .in_entry  (stage_entry),
      .out_ready (ctrl_ready),
      .in_ready  (fifo_ready),
      .out_valid (fifo_valid),
      .out_entry (fifo_entry)
   );

   mem_access_ctrl ctrl0 (
      .memclk    (memclk),
      .reset     (reset),
      .in_valid  (fifo_valid),
      .in_entry  (fifo_entry),
      .dout      (dout),
      .rsp_ready (rsp_ready),
      .in_ready  (ctrl_ready),
      .ce        (ce),
      .rdwen     (rdwen),
      .a         (a),
      .bw        (bw),
      .din       (din),
      .rsp_valid (rsp_valid),
      .rsp_rdata (rsp_rdata)
   );

   sram_1rw_512x128 sram0 (
      .memclk (memclk),
      .reset  (reset),
      .ce     (ce),
      .a      (a),
      .rdwen  (rdwen),
      .bw     (bw),
      .din    (din),
      .dout   (dout)
   );

endmodule

// ==== verilog/sram_1rw_512x128.sv ====
// Single-port SRAM wrapper
`timescale 1ns/1ps

module sram_1rw_512x128 (
   input  logic                       memclk,
   input  logic                       reset,
   input  logic                       ce,
   input  logic [mem_pkg::ADDR_W-1:0] a,
   input  logic                       rdwen,
   input  logic [mem_pkg::DATA_W-1:0] bw,
   input  logic [mem_pkg::DATA_W-1:0] din,
   output logic [mem_pkg::DATA_W-1:0] dout
);

   logic                     write_en;
   logic                     read_en;
   logic [mem_pkg::BE_W-1:0] wen_mask;

   // rdwen high selects a read, low a write.
   // no access reaches the array while reset is held.
   assign write_en = ce & ~rdwen & ~reset;
   assign read_en  = ce & rdwen & ~reset;

   // bit mask is byte uniform, so bit 0 of each lane stands for the byte.
   for (genvar i = 0; i < mem_pkg::BE_W; i++) begin : g_lane
      assign wen_mask[i] = bw[8*i];
   end

   // one address shared by both ports, single clock.
   bram_512x128 bram0 (
      .clka  (memclk),
      .ena   (write_en),
      .wea   (wen_mask),
      .addra (a),
      .dina  (din),
      .clkb  (memclk),
      .enb   (read_en),
      .addrb (a),
      .doutb (dout)
   );

endmodule
